/* common/mips_pkg.sv */
package mips_pkg;

    // Datapath and memory sizes
    localparam int data_width      = 32;
    localparam int pc_width        = 11;
    localparam int reg_addr_width  = 5;
    localparam int reg_count       = 2 ** reg_addr_width;
    localparam int imem_depth      = 64;
    localparam int dmem_depth      = 64;
    localparam int imem_addr_width = $clog2(imem_depth);
    localparam int dmem_addr_width = $clog2(dmem_depth);

    // Program image loaded into instruction memory
    localparam string imem_init_file = "bench/program.hex";

    // Primary opcode field, instruction[31:26]
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_beq   = 6'h04,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    // Function field of R-type, instruction[5:0]
    typedef enum logic [5:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

    // Coarse ALU request from decode
    typedef enum logic [1:0] {
        aluop_add   = 2'b00,
        aluop_sub   = 2'b01,
        aluop_funct = 2'b10
    } alu_op_e;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_ctrl_e;

    // Operand source chosen by the forwarding unit
    typedef enum logic [1:0] {
        fwd_none = 2'b00,
        fwd_wb   = 2'b01,
        fwd_mem  = 2'b10
    } fwd_sel_e;

endpackage

/* src/instruction_fetch.sv */
`timescale 1ns/1ps

module instruction_fetch import mips_pkg::*; (
    input  logic                  pipeline_clock,
    input  logic                  reset,
    input  logic                  branch_taken,
    input  logic [pc_width-1:0]   branch_target,
    output logic [pc_width-1:0]   pc,
    output logic [data_width-1:0] instruction
);

    logic [data_width-1:0] imem [imem_depth];
    logic [pc_width-1:0]   pc_current;

    initial begin
        $readmemh(imem_init_file, imem);
    end

    // Program counter, redirected by a branch resolved in MEM
    always_ff @(posedge pipeline_clock) begin
        if (reset) begin
            pc_current <= '0;
        end else if (branch_taken) begin
            pc_current <= branch_target;
        end else begin
            pc_current <= pc_current + 1'b1;
        end
    end

    // IF/ID register
    always_ff @(posedge pipeline_clock) begin
        if (reset) begin
            pc          <= '0;
            instruction <= '0;
        end else begin
            pc          <= pc_current + 1'b1;
            instruction <= imem[pc_current[imem_addr_width-1:0]];
        end
    end

    // Branch targets and fall-through must stay inside the program image
    assert property (@(posedge pipeline_clock) disable iff (reset)
        pc_current < imem_depth);

endmodule

/* decode/instruction_decode.sv */
`timescale 1ns/1ps

module instruction_decode import mips_pkg::*; (
    input  logic                      pipeline_clock,
    input  logic                      reset,
    input  logic [data_width-1:0]     instruction,
    input  logic [pc_width-1:0]       pc,
    input  logic                      wb_reg_write,
    input  logic [reg_addr_width-1:0] wb_addr,
    input  logic [data_width-1:0]     wb_data,
    input  logic [reg_addr_width-1:0] dbg_reg_addr,
    output logic [data_width-1:0]     dbg_reg_data,
    output logic [data_width-1:0]     data_a,
    output logic [data_width-1:0]     data_b,
    output logic [data_width-1:0]     sign_ext,
    output logic [pc_width-1:0]       branch_target,
    output logic [reg_addr_width-1:0] rs,
    output logic [reg_addr_width-1:0] rt,
    output logic [reg_addr_width-1:0] rd,
    output logic                      reg_dst,
    output logic                      alu_src,
    output alu_op_e                   alu_op,
    output logic                      mem_to_reg,
    output logic                      reg_write,
    output logic                      mem_read,
    output logic                      mem_write,
    output logic                      branch
);

    logic [data_width-1:0]     registers [reg_count];
    opcode_e                   opcode;
    logic [reg_addr_width-1:0] rs_addr;
    logic [reg_addr_width-1:0] rt_addr;
    logic [reg_addr_width-1:0] rd_addr;
    logic [data_width-1:0]     read_a;
    logic [data_width-1:0]     read_b;
    logic [data_width-1:0]     imm_ext;
    logic                      ctl_reg_dst;
    logic                      ctl_alu_src;
    alu_op_e                   ctl_alu_op;
    logic                      ctl_mem_to_reg;
    logic                      ctl_reg_write;
    logic                      ctl_mem_read;
    logic                      ctl_mem_write;
    logic                      ctl_branch;

    assign opcode  = opcode_e'(instruction[31:26]);
    assign rs_addr = instruction[25:21];
    assign rt_addr = instruction[20:16];
    assign rd_addr = instruction[15:11];
    assign imm_ext = {{(data_width-16){instruction[15]}}, instruction[15:0]};

    // **********************************************
    // Register file
    // **********************************************

    // Read with bypass of a same-cycle write-back
    function automatic logic [data_width-1:0] read_port(input logic [reg_addr_width-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_reg_write && wb_addr == addr) begin
            return wb_data;
        end
        return registers[addr];
    endfunction

    always_comb begin
        read_a = read_port(rs_addr);
        read_b = read_port(rt_addr);
    end

    assign dbg_reg_data = (dbg_reg_addr == '0) ? '0 : registers[dbg_reg_addr];

    always_ff @(posedge pipeline_clock) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                registers[i] <= '0;
            end
        end else if (wb_reg_write && wb_addr != '0) begin
            registers[wb_addr] <= wb_data;
        end
    end

    // **********************************************
    // Main control
    // **********************************************
    always_comb begin
        ctl_reg_dst    = 1'b0;
        ctl_alu_src    = 1'b0;
        ctl_alu_op     = aluop_add;
        ctl_mem_to_reg = 1'b0;
        ctl_reg_write  = 1'b0;
        ctl_mem_read   = 1'b0;
        ctl_mem_write  = 1'b0;
        ctl_branch     = 1'b0;
        // All-zero word is a nop
        if (instruction != '0) begin
            case (opcode)
                op_rtype: begin
                    ctl_reg_dst   = 1'b1;
                    ctl_alu_op    = aluop_funct;
                    ctl_reg_write = 1'b1;
                end
                op_addi: begin
                    ctl_alu_src   = 1'b1;
                    ctl_reg_write = 1'b1;
                end
                op_lw: begin
                    ctl_alu_src    = 1'b1;
                    ctl_mem_to_reg = 1'b1;
                    ctl_reg_write  = 1'b1;
                    ctl_mem_read   = 1'b1;
                end
                op_sw: begin
                    ctl_alu_src   = 1'b1;
                    ctl_mem_write = 1'b1;
                end
                op_beq: begin
                    ctl_alu_op = aluop_sub;
                    ctl_branch = 1'b1;
                end
                default: ;
            endcase
        end
    end

    // ID/EX register
    always_ff @(posedge pipeline_clock) begin
        if (reset) begin
            data_a        <= '0;
            data_b        <= '0;
            sign_ext      <= '0;
            branch_target <= '0;
            rs            <= '0;
            rt            <= '0;
            rd            <= '0;
            reg_dst       <= 1'b0;
            alu_src       <= 1'b0;
            alu_op        <= aluop_add;
            mem_to_reg    <= 1'b0;
            reg_write     <= 1'b0;
            mem_read      <= 1'b0;
            mem_write     <= 1'b0;
            branch        <= 1'b0;
        end else begin
            data_a        <= read_a;
            data_b        <= read_b;
            sign_ext      <= imm_ext;
            // pc already points past this instruction
            branch_target <= pc + imm_ext[pc_width-1:0];
            rs            <= rs_addr;
            rt            <= rt_addr;
            rd            <= rd_addr;
            reg_dst       <= ctl_reg_dst;
            alu_src       <= ctl_alu_src;
            alu_op        <= ctl_alu_op;
            mem_to_reg    <= ctl_mem_to_reg;
            reg_write     <= ctl_reg_write;
            mem_read      <= ctl_mem_read;
            mem_write     <= ctl_mem_write;
            branch        <= ctl_branch;
        end
    end

    // Register 0 reaches execute as zero, even under a write-back to it
    assert property (@(posedge pipeline_clock) disable iff (reset)
        (rs_addr == '0) |=> (data_a == '0));

endmodule

/* src/execute.sv */
`timescale 1ns/1ps

module execute import mips_pkg::*; (
    input  logic                      pipeline_clock,
    input  logic                      reset,
    input  logic [data_width-1:0]     data_a,
    input  logic [data_width-1:0]     data_b,
    input  logic [data_width-1:0]     sign_ext,
    input  logic [pc_width-1:0]       branch_target,
    input  logic [reg_addr_width-1:0] rs,
    input  logic [reg_addr_width-1:0] rt,
    input  logic [reg_addr_width-1:0] rd,
    input  logic                      reg_dst,
    input  logic                      alu_src,
    input  alu_op_e                   alu_op,
    input  logic                      mem_to_reg,
    input  logic                      reg_write,
    input  logic                      mem_read,
    input  logic                      mem_write,
    input  logic                      branch,
    input  fwd_sel_e                  forward_a,
    input  fwd_sel_e                  forward_b,
    input  logic [data_width-1:0]     mem_fwd_data,
    input  logic [data_width-1:0]     wb_data,
    output logic [data_width-1:0]     alu_result,
    output logic [data_width-1:0]     store_data,
    output logic [reg_addr_width-1:0] dest,
    output logic                      zero,
    output logic [pc_width-1:0]       branch_target_ex,
    output logic                      mem_to_reg_ex,
    output logic                      reg_write_ex,
    output logic                      mem_read_ex,
    output logic                      mem_write_ex,
    output logic                      branch_ex
);

    logic [data_width-1:0] operand_a;
    logic [data_width-1:0] fwd_b_value;
    logic [data_width-1:0] operand_b;
    logic [data_width-1:0] result;
    funct_e                funct;
    alu_ctrl_e             alu_ctrl;

    function automatic logic [data_width-1:0] select_operand(input fwd_sel_e sel,
                                                             input logic [data_width-1:0] reg_value);
        case (sel)
            fwd_mem: return mem_fwd_data;
            fwd_wb:  return wb_data;
            default: return reg_value;
        endcase
    endfunction

    always_comb begin
        operand_a   = select_operand(forward_a, data_a);
        fwd_b_value = select_operand(forward_b, data_b);
        operand_b   = alu_src ? sign_ext : fwd_b_value;
    end

    // ALU control from the coarse request and the funct field
    assign funct = funct_e'(sign_ext[5:0]);

    always_comb begin
        case (alu_op)
            aluop_sub: alu_ctrl = alu_sub;
            aluop_funct: begin
                case (funct)
                    fn_sub:  alu_ctrl = alu_sub;
                    fn_and:  alu_ctrl = alu_and;
                    fn_or:   alu_ctrl = alu_or;
                    fn_slt:  alu_ctrl = alu_slt;
                    default: alu_ctrl = alu_add;
                endcase
            end
            default: alu_ctrl = alu_add;
        endcase
    end

    always_comb begin
        case (alu_ctrl)
            alu_sub: result = operand_a - operand_b;
            alu_and: result = operand_a & operand_b;
            alu_or:  result = operand_a | operand_b;
            alu_slt: result = {{(data_width-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            default: result = operand_a + operand_b;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge pipeline_clock) begin
        if (reset) begin
            alu_result       <= '0;
            store_data       <= '0;
            dest             <= '0;
            zero             <= 1'b0;
            branch_target_ex <= '0;
            mem_to_reg_ex    <= 1'b0;
            reg_write_ex     <= 1'b0;
            mem_read_ex      <= 1'b0;
            mem_write_ex     <= 1'b0;
            branch_ex        <= 1'b0;
        end else begin
            alu_result       <= result;
            store_data       <= fwd_b_value;
            dest             <= reg_dst ? rd : rt;
            zero             <= (result == '0);
            branch_target_ex <= branch_target;
            mem_to_reg_ex    <= mem_to_reg;
            reg_write_ex     <= reg_write;
            mem_read_ex      <= mem_read;
            mem_write_ex     <= mem_write;
            branch_ex        <= branch;
        end
    end

    // A MEM forward of operand A must come from the instruction just ahead
    assert property (@(posedge pipeline_clock) disable iff (reset)
        (forward_a == fwd_mem) |-> (reg_write_ex && dest == rs && rs != '0));

endmodule

/* src/memory_access.sv */
`timescale 1ns/1ps

module memory_access import mips_pkg::*; (
    input  logic                      pipeline_clock,
    input  logic                      reset,
    input  logic [data_width-1:0]     alu_result,
    input  logic [data_width-1:0]     store_data,
    input  logic [reg_addr_width-1:0] dest,
    input  logic                      zero,
    input  logic                      mem_to_reg,
    input  logic                      reg_write,
    input  logic                      mem_read,
    input  logic                      mem_write,
    input  logic                      branch,
    output logic                      branch_taken,
    output logic [data_width-1:0]     mem_fwd_data,
    output logic                      wb_reg_write,
    output logic [reg_addr_width-1:0] wb_addr,
    output logic [data_width-1:0]     wb_data
);

    logic [data_width-1:0]      data_mem [dmem_depth];
    logic [dmem_addr_width-1:0] mem_addr;
    logic [data_width-1:0]      read_data_wb;
    logic [data_width-1:0]      alu_result_wb;
    logic                       mem_to_reg_wb;

    // Word addressed, upper address bits ignored
    assign mem_addr     = alu_result[dmem_addr_width-1:0];
    assign branch_taken = branch && zero;
    assign mem_fwd_data = alu_result;

    always_ff @(posedge pipeline_clock) begin
        if (mem_write && !reset) begin
            data_mem[mem_addr] <= store_data;
        end
    end

    // MEM/WB register
    always_ff @(posedge pipeline_clock) begin
        if (reset) begin
            read_data_wb  <= '0;
            alu_result_wb <= '0;
            wb_addr       <= '0;
            mem_to_reg_wb <= 1'b0;
            wb_reg_write  <= 1'b0;
        end else begin
            read_data_wb  <= mem_read ? data_mem[mem_addr] : '0;
            alu_result_wb <= alu_result;
            wb_addr       <= dest;
            mem_to_reg_wb <= mem_to_reg;
            wb_reg_write  <= reg_write;
        end
    end

    // Write-back select
    assign wb_data = mem_to_reg_wb ? read_data_wb : alu_result_wb;

    // Decode never issues a load and a store in one instruction
    assert property (@(posedge pipeline_clock) disable iff (reset)
        !(mem_read && mem_write));

endmodule

/* src/forwarding_unit.sv */
`timescale 1ns/1ps

module forwarding_unit import mips_pkg::*; (
    input  logic [reg_addr_width-1:0] ex_mem_rd,
    input  logic                      ex_mem_reg_write,
    input  logic [reg_addr_width-1:0] mem_wb_rd,
    input  logic                      mem_wb_reg_write,
    input  logic [reg_addr_width-1:0] id_ex_rs,
    input  logic [reg_addr_width-1:0] id_ex_rt,
    output fwd_sel_e                  forward_a,
    output fwd_sel_e                  forward_b
);

    // Younger result in EX/MEM wins over MEM/WB
    function automatic fwd_sel_e pick_source(input logic [reg_addr_width-1:0] src);
        if (ex_mem_reg_write && ex_mem_rd != '0 && ex_mem_rd == src) begin
            return fwd_mem;
        end
        if (mem_wb_reg_write && mem_wb_rd != '0 && mem_wb_rd == src) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    always_comb begin
        forward_a = pick_source(id_ex_rs);
        forward_b = pick_source(id_ex_rt);
    end

    always_comb begin
        assert final (id_ex_rs != '0 || forward_a == fwd_none);
        assert final (id_ex_rt != '0 || forward_b == fwd_none);
    end

endmodule

/* src/pipeline.sv */
`timescale 1ns/1ps

module pipeline import mips_pkg::*; (
    input  logic                      pipeline_clock,
    input  logic                      reset,
    output logic                      wb_valid,
    output logic [reg_addr_width-1:0] wb_addr,
    output logic [data_width-1:0]     wb_data,
    input  logic [reg_addr_width-1:0] dbg_reg_addr,
    output logic [data_width-1:0]     dbg_reg_data
);

    // IF/ID
    logic [pc_width-1:0]       if_pc;
    logic [data_width-1:0]     if_instruction;

    // ID/EX
    logic [data_width-1:0]     id_data_a;
    logic [data_width-1:0]     id_data_b;
    logic [data_width-1:0]     id_sign_ext;
    logic [pc_width-1:0]       id_branch_target;
    logic [reg_addr_width-1:0] id_rs;
    logic [reg_addr_width-1:0] id_rt;
    logic [reg_addr_width-1:0] id_rd;
    logic                      id_reg_dst;
    logic                      id_alu_src;
    alu_op_e                   id_alu_op;
    logic                      id_mem_to_reg;
    logic                      id_reg_write;
    logic                      id_mem_read;
    logic                      id_mem_write;
    logic                      id_branch;

    // EX/MEM
    logic [data_width-1:0]     ex_alu_result;
    logic [data_width-1:0]     ex_store_data;
    logic [reg_addr_width-1:0] ex_dest;
    logic                      ex_zero;
    logic [pc_width-1:0]       ex_branch_target;
    logic                      ex_mem_to_reg;
    logic                      ex_reg_write;
    logic                      ex_mem_read;
    logic                      ex_mem_write;
    logic                      ex_branch;

    // MEM/WB and feedback paths
    logic                      branch_taken;
    logic [data_width-1:0]     mem_fwd_data;
    logic                      wb_reg_write;
    fwd_sel_e                  forward_a;
    fwd_sel_e                  forward_b;

    // Retire stream straight from the write-back stage
    assign wb_valid = wb_reg_write;

    // ************************************************
    instruction_fetch u_instruction_fetch (
        .pipeline_clock (pipeline_clock),
        .reset          (reset),
        .branch_taken   (branch_taken),
        .branch_target  (ex_branch_target),
        .pc             (if_pc),
        .instruction    (if_instruction)
    );

    instruction_decode u_instruction_decode (
        .pipeline_clock (pipeline_clock),
        .reset          (reset),
        .instruction    (if_instruction),
        .pc             (if_pc),
        .wb_reg_write   (wb_reg_write),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data),
        .dbg_reg_addr   (dbg_reg_addr),
        .dbg_reg_data   (dbg_reg_data),
        .data_a         (id_data_a),
        .data_b         (id_data_b),
        .sign_ext       (id_sign_ext),
        .branch_target  (id_branch_target),
        .rs             (id_rs),
        .rt             (id_rt),
        .rd             (id_rd),
        .reg_dst        (id_reg_dst),
        .alu_src        (id_alu_src),
        .alu_op         (id_alu_op),
        .mem_to_reg     (id_mem_to_reg),
        .reg_write      (id_reg_write),
        .mem_read       (id_mem_read),
        .mem_write      (id_mem_write),
        .branch         (id_branch)
    );

    // ************************************************
    execute u_execute (
        .pipeline_clock   (pipeline_clock),
        .reset            (reset),
        .data_a           (id_data_a),
        .data_b           (id_data_b),
        .sign_ext         (id_sign_ext),
        .branch_target    (id_branch_target),
        .rs               (id_rs),
        .rt               (id_rt),
        .rd               (id_rd),
        .reg_dst          (id_reg_dst),
        .alu_src          (id_alu_src),
        .alu_op           (id_alu_op),
        .mem_to_reg       (id_mem_to_reg),
        .reg_write        (id_reg_write),
        .mem_read         (id_mem_read),
        .mem_write        (id_mem_write),
        .branch           (id_branch),
        .forward_a        (forward_a),
        .forward_b        (forward_b),
        .mem_fwd_data     (mem_fwd_data),
        .wb_data          (wb_data),
        .alu_result       (ex_alu_result),
        .store_data       (ex_store_data),
        .dest             (ex_dest),
        .zero             (ex_zero),
        .branch_target_ex (ex_branch_target),
        .mem_to_reg_ex    (ex_mem_to_reg),
        .reg_write_ex     (ex_reg_write),
        .mem_read_ex      (ex_mem_read),
        .mem_write_ex     (ex_mem_write),
        .branch_ex        (ex_branch)
    );

    memory_access u_memory_access (
        .pipeline_clock (pipeline_clock),
        .reset          (reset),
        .alu_result     (ex_alu_result),
        .store_data     (ex_store_data),
        .dest           (ex_dest),
        .zero           (ex_zero),
        .mem_to_reg     (ex_mem_to_reg),
        .reg_write      (ex_reg_write),
        .mem_read       (ex_mem_read),
        .mem_write      (ex_mem_write),
        .branch         (ex_branch),
        .branch_taken   (branch_taken),
        .mem_fwd_data   (mem_fwd_data),
        .wb_reg_write   (wb_reg_write),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data)
    );

    forwarding_unit u_forwarding_unit (
        .ex_mem_rd        (ex_dest),
        .ex_mem_reg_write (ex_reg_write),
        .mem_wb_rd        (wb_addr),
        .mem_wb_reg_write (wb_reg_write),
        .id_ex_rs         (id_rs),
        .id_ex_rt         (id_rt),
        .forward_a        (forward_a),
        .forward_b        (forward_b)
    );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clock,
    output logic reset
);

    // 20 ns period
    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Two clock edges in reset, released off the edge like other inputs
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clock);
        #2 reset = 1'b0;
    end

endmodule

/* bench/pipeline_tb.sv */
`timescale 1ns/1ps

module pipeline_tb import mips_pkg::*; ();

    localparam int program_words   = 40;
    localparam int branch_cycles   = 24;
    localparam int dump_cycles     = 64;
    localparam int margin_cycles   = 72;
    localparam int watchdog_cycles = program_words + branch_cycles + dump_cycles + margin_cycles;

    logic                      clock;
    logic                      reset;
    logic                      wb_valid;
    logic [reg_addr_width-1:0] wb_addr;
    logic [data_width-1:0]     wb_data;
    logic [reg_addr_width-1:0] dbg_reg_addr;
    logic [data_width-1:0]     dbg_reg_data;

    // Expected retire stream and register image
    logic [reg_addr_width-1:0] exp_addr_q [$];
    logic [data_width-1:0]     exp_data_q [$];
    logic [data_width-1:0]     model_regs [reg_count];
    logic [data_width-1:0]     reg_image [reg_count] = '{default: '0};
    int                        head_index = 0;
    int                        order [reg_count];
    int                        fail_count = 0;
    logic [reg_addr_width-1:0] exp_addr;
    logic [data_width-1:0]     exp_data;
    logic                      exp_pending;
    logic [data_width-1:0]     dbg_expected;

    tb_clock u_tb_clock (
        .clock (clock),
        .reset (reset)
    );

    pipeline u_dut (
        .pipeline_clock (clock),
        .reset          (reset),
        .wb_valid       (wb_valid),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data),
        .dbg_reg_addr   (dbg_reg_addr),
        .dbg_reg_data   (dbg_reg_data)
    );

    assign exp_pending  = head_index < exp_addr_q.size();
    assign exp_addr     = exp_addr_q[head_index];
    assign exp_data     = exp_data_q[head_index];
    assign dbg_expected = reg_image[dbg_reg_addr];

    task automatic flag_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        fail_count++;
        $display("FAIL %s expected %08h actual %08h", name, expected, actual);
        $display("Checks failed");
        $fatal(1, "stopping at the first failed check");
    endtask

    task automatic abort_run(input string what);
        fail_count++;
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "stopping at the first failed check");
    endtask

    // Signs differ: the negative one is less; same sign: plain magnitude order
    function automatic logic [data_width-1:0] slt_ref(input logic [data_width-1:0] a,
                                                      input logic [data_width-1:0] b);
        if (a[data_width-1] != b[data_width-1]) begin
            return {{(data_width-1){1'b0}}, a[data_width-1]};
        end
        return (a < b) ? 32'd1 : 32'd0;
    endfunction

    // Register 0 shows on the trace but keeps its zero value
    task automatic write_reg(input int addr, input logic [data_width-1:0] value);
        exp_addr_q.push_back(addr[reg_addr_width-1:0]);
        exp_data_q.push_back(value);
        if (addr != 0) begin
            model_regs[addr] = value;
        end
    endtask

    // **************************************************
    // ISA walk of bench/program.hex
    // **************************************************
    task automatic build_expected();
        logic [data_width-1:0] stored_word;
        for (int i = 0; i < reg_count; i++) begin
            model_regs[i] = '0;
        end
        write_reg(1, model_regs[0] + 32'd5);
        write_reg(2, model_regs[0] + 32'hffff_fff4);
        // Words 2 and 3 need the EX/MEM and MEM/WB forwards
        write_reg(3, model_regs[1] + model_regs[2]);
        write_reg(4, model_regs[3] - model_regs[1]);
        // slt with a negative, then a positive difference
        write_reg(5, slt_ref(model_regs[4], model_regs[1]));
        write_reg(6, slt_ref(model_regs[1], model_regs[4]));
        write_reg(7, model_regs[1] & model_regs[2]);
        write_reg(8, model_regs[1] | model_regs[2]);
        // sw $8 to word 4, then add into $0
        stored_word = model_regs[8];
        write_reg(0, model_regs[1] + model_regs[1]);
        write_reg(9, stored_word);
        write_reg(10, model_regs[1] + model_regs[1]);
        write_reg(11, model_regs[9] + model_regs[10]);
        // beq $1,$2 falls through; beq $10,$10 skips words 21 and 22
        write_reg(14, model_regs[11] + 32'd2);
    endtask

    task automatic shuffle_order();
        int j;
        int tmp;
        for (int i = 0; i < reg_count; i++) begin
            order[i] = i;
        end
        for (int i = reg_count - 1; i > 0; i--) begin
            j        = $urandom % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
    endtask

    // Advance the queue head on each retired write
    always @(posedge clock) begin
        if (!reset && wb_valid && exp_pending) begin
            if (exp_addr != '0) begin
                reg_image[exp_addr] <= exp_data;
            end
            head_index <= head_index + 1;
        end
    end

    // **************************************************
    // Checks
    // **************************************************
    quiet_in_reset: assert property (@(posedge clock) (reset || $fell(reset)) |=> !wb_valid)
        else abort_run("wb_valid was high during reset or in the cycle after it");

    no_extra_write: assert property (@(posedge clock) disable iff (reset)
        wb_valid |-> exp_pending)
        else abort_run("a write-back came after the expected sequence had ended");

    wb_addr_match: assert property (@(posedge clock) disable iff (reset)
        (wb_valid && exp_pending) |-> (wb_addr == exp_addr))
        else flag_mismatch("wb_addr", $sampled(exp_addr), $sampled(wb_addr));

    wb_data_match: assert property (@(posedge clock) disable iff (reset)
        (wb_valid && exp_pending) |-> (wb_data == exp_data))
        else flag_mismatch("wb_data", $sampled(exp_data), $sampled(wb_data));

    dbg_match: assert property (@(posedge clock) disable iff (reset)
        dbg_reg_data == dbg_expected)
        else flag_mismatch("dbg_reg_data", $sampled(dbg_expected), $sampled(dbg_reg_data));

    initial begin
        void'($urandom(46));
        dbg_reg_addr = '0;
        build_expected();
        @(negedge reset);
        // Walk the register file right after reset while it still reads zero
        for (int i = 0; i < reg_count; i++) begin
            @(posedge clock);
            #2 dbg_reg_addr = i[reg_addr_width-1:0];
        end
        wait (head_index == exp_addr_q.size());
        shuffle_order();
        for (int i = 0; i < reg_count; i++) begin
            @(posedge clock);
            #2 dbg_reg_addr = order[i][reg_addr_width-1:0];
        end
        @(posedge clock);
        #1;
        if (fail_count == 0 && head_index == exp_addr_q.size()) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("Timeout: the program did not finish within %0d cycles", watchdog_cycles);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule

/* compile.f */
common/mips_pkg.sv
src/instruction_fetch.sv
decode/instruction_decode.sv
src/execute.sv
src/memory_access.sv
src/forwarding_unit.sv
src/pipeline.sv
bench/tb_clock.sv
bench/pipeline_tb.sv

/* Bender.yml */
package:
  name: mips_pipeline

sources:
  - common/mips_pkg.sv
  - src/instruction_fetch.sv
  - decode/instruction_decode.sv
  - src/execute.sv
  - src/memory_access.sv
  - src/forwarding_unit.sv
  - src/pipeline.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/pipeline_tb.sv

/* bench/program.hex */
// One 32-bit instruction word per line, word address 0 first
// Column: hex instruction word, then the mnemonic
20010005 // 0  addi $1, $0, 5
2002fff4 // 1  addi $2, $0, -12
00221820 // 2  add  $3, $1, $2
00612022 // 3  sub  $4, $3, $1
0081282a // 4  slt  $5, $4, $1
0024302a // 5  slt  $6, $1, $4
00223824 // 6  and  $7, $1, $2
00224025 // 7  or   $8, $1, $2
ac080004 // 8  sw   $8, 4($0)
00210020 // 9  add  $0, $1, $1
8c090004 // 10 lw   $9, 4($0)
00215020 // 11 add  $10, $1, $1
012a5820 // 12 add  $11, $9, $10
10220004 // 13 beq  $1, $2, 4
00000000 // 14 nop
00000000 // 15 nop
00000000 // 16 nop
114a0005 // 17 beq  $10, $10, 5
00000000 // 18 nop
00000000 // 19 nop
00000000 // 20 nop
200c0077 // 21 addi $12, $0, 0x77
200d0066 // 22 addi $13, $0, 0x66
216e0002 // 23 addi $14, $11, 2
1000ffff // 24 beq  $0, $0, -1
00000000 // 25 nop
00000000 // 26 nop
00000000 // 27 nop
